// File: Makefile
# Verilator build and run for the ROM loader testbench

VERILATOR ?= verilator
TOP       ?= tb_rom_loader
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
+incdir+rtl
rtl/loader_pkg.sv
rtl/addr_remap.sv
rtl/dwnld_fsm.sv
rtl/frac_cen.sv
rtl/rom_loader_top.sv
tb/loader_assertions.sv
tb/loader_checker.sv
tb/tb_rom_loader.sv

// File: rtl/addr_remap.sv
// Download address remapping
`timescale 1ns/100ps

`include "loader_params.svh"

module addr_remap (
    input  loader_pkg::dl_addr_u  ioctl_addr,
    input  logic [7:0]            ioctl_dout,
    output loader_pkg::region_e   region,
    output logic [`DL_AW-1:0]     remap_addr,
    output logic [7:0]            remap_data
);
    import loader_pkg::*;

    localparam logic [`DL_AW-1:0] scr_start  = `DL_AW'(`SCR_START);
    localparam logic [`DL_AW-1:0] obj_start  = `DL_AW'(`OBJ_START);
    localparam logic [`DL_AW-1:0] prom_start = `PROM_START;

    // Region decode on the plain byte offset
    always_comb begin
        if (ioctl_addr.linear >= prom_start) begin
            region = rgn_prom;
        end else if (ioctl_addr.linear >= obj_start) begin
            region = rgn_object;
        end else if (ioctl_addr.linear >= scr_start) begin
            region = rgn_scroll;
        end else begin
            region = rgn_code;
        end
    end

    always_comb begin
        remap_addr = ioctl_addr.linear;
        remap_data = ioctl_dout;
        case (region)
            rgn_scroll: begin
                // Nibble order differs from what the scroll renderer expects
                remap_data = {ioctl_dout[3:0], ioctl_dout[7:4]};
            end
            rgn_object: begin
                // Reorder so one 32-bit fetch returns a full object row
                remap_addr[15]  = ioctl_addr.tile.b0;
                remap_addr[14]  = ioctl_addr.tile.b15;
                remap_addr[0]   = ioctl_addr.tile.b14;
                remap_addr[2:1] = ioctl_addr.tile.pair + 2'd1;
                remap_addr[6:3] = {ioctl_addr.tile.b6, ioctl_addr.tile.b3_1};
            end
            rgn_prom: begin
                remap_addr = ioctl_addr.linear - prom_start;
            end
            default: begin
                // CPU code goes through as is
                remap_addr = ioctl_addr.linear;
            end
        endcase
    end

endmodule

// File: rtl/dwnld_fsm.sv
// Download write sequencer
`timescale 1ns/100ps

`include "loader_params.svh"

module dwnld_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 downloading,
    input  logic                 ioctl_wr,
    input  loader_pkg::region_e  region,
    input  logic [`DL_AW-1:0]    remap_addr,
    input  logic [7:0]           remap_data,
    input  logic                 sdram_ack,
    output logic [`PROG_AW-1:0]  prog_addr,
    output logic [7:0]           prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    output logic                 prom_we
);
    import loader_pkg::*;

    localparam logic [1:0] st_idle       = 2'd0;
    localparam logic [1:0] st_sdram_wait = 2'd1;
    localparam logic [1:0] st_prom_pulse = 2'd2;

    logic [1:0] state;
    logic       accept;

    // Strobes outside idle are lost since the downloader is slower than SDRAM
    assign accept = downloading && ioctl_wr && (state == st_idle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= (region == rgn_prom) ? st_prom_pulse : st_sdram_wait;
                    end
                end
                st_sdram_wait: begin
                    if (sdram_ack) begin
                        state <= st_idle;
                    end
                end
                st_prom_pulse: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Write payload captured once per accepted byte
    always_ff @(posedge clk) begin
        if (accept) begin
            prog_data <= remap_data;
            // Active low mask with the even byte in the low half
            prog_mask <= remap_addr[0] ? 2'b01 : 2'b10;
            if (region == rgn_prom) begin
                prog_addr <= remap_addr[`PROG_AW-1:0];
            end else begin
                prog_addr <= remap_addr[`PROG_AW:1];
            end
        end
    end

    assign prog_we = (state == st_sdram_wait);
    assign prom_we = (state == st_prom_pulse);

endmodule

// File: rtl/frac_cen.sv
// Fractional pixel clock enables
`timescale 1ns/100ps

module frac_cen (
    input  logic clk,
    input  logic rst_n,
    input  logic vsync60,
    output logic pxl2_cen,
    output logic pxl_cen
);
    logic [9:0] n;
    logic [9:0] m;
    logic [9:0] acc;
    logic [9:0] sum;
    logic       half;

    // Ratio 1/4 for the 60 Hz setting and 32/125 otherwise
    assign n   = vsync60 ? 10'd1 : 10'd32;
    assign m   = vsync60 ? 10'd4 : 10'd125;
    assign sum = acc + n;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc      <= 10'd0;
            half     <= 1'b0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else if (sum >= m) begin
            acc      <= sum - m;
            half     <= ~half;
            pxl2_cen <= 1'b1;
            // Every second pxl2 pulse starting with the second
            pxl_cen  <= half;
        end else begin
            acc      <= sum;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end
    end

endmodule

// File: rtl/loader_params.svh
// ROM loader memory map
`ifndef LOADER_PARAMS_SVH
`define LOADER_PARAMS_SVH

// Byte offsets in the download stream
// Below SCR_START lies CPU code
`define SCR_START   22'h10000
`define OBJ_START   22'h18000

// PROM bytes are routed away from SDRAM
`define PROM_START  25'h20000

// Download byte address width
`define DL_AW       25

// SDRAM 16-bit word address width
`define PROG_AW     22

`endif

// File: rtl/loader_pkg.sv
// ROM loader shared types
package loader_pkg;

    // Download byte address, read either as a plain offset or as tile fields
    typedef struct packed {
        logic [8:0] upper;      // Bits 24..16
        logic       b15;
        logic       b14;
        logic [6:0] mid;        // Bits 13..7
        logic       b6;
        logic [1:0] pair;       // Bits 5..4 select the object sub-tile
        logic [2:0] b3_1;
        logic       b0;
    } tile_addr_t;

    typedef union packed {
        logic [24:0] linear;
        tile_addr_t  tile;
    } dl_addr_u;

    // Destination of a downloaded byte
    typedef enum logic [1:0] {
        rgn_code   = 2'd0,
        rgn_scroll = 2'd1,
        rgn_object = 2'd2,
        rgn_prom   = 2'd3
    } region_e;

endpackage

// File: rtl/rom_loader_top.sv
// ROM loader top level
`timescale 1ns/100ps

`include "loader_params.svh"

module rom_loader_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 vsync60,
    // Download stream
    input  logic                 downloading,
    input  logic [`DL_AW-1:0]    ioctl_addr,
    input  logic [7:0]           ioctl_dout,
    input  logic                 ioctl_wr,
    input  logic                 sdram_ack,
    output logic                 dwnld_busy,
    // SDRAM programming
    output logic [`PROG_AW-1:0]  prog_addr,
    output logic [7:0]           prog_data,
    output logic [1:0]           prog_mask,   // active low
    output logic                 prog_we,
    output logic                 prom_we,
    // Pixel enables
    output logic                 pxl2_cen,    // ~12 MHz
    output logic                 pxl_cen      // ~6 MHz
);
    import loader_pkg::*;

    region_e            region;
    logic [`DL_AW-1:0]  remap_addr;
    logic [7:0]         remap_data;

    assign dwnld_busy = downloading;

    addr_remap u_addr_remap (
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .region      ( region      ),
        .remap_addr  ( remap_addr  ),
        .remap_data  ( remap_data  )
    );

    dwnld_fsm u_dwnld_fsm (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .region      ( region      ),
        .remap_addr  ( remap_addr  ),
        .remap_data  ( remap_data  ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    frac_cen u_frac_cen (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .vsync60     ( vsync60     ),
        .pxl2_cen    ( pxl2_cen    ),
        .pxl_cen     ( pxl_cen     )
    );

endmodule

// File: tb/loader_assertions.sv
// Download write protocol assertions
`timescale 1ns/100ps

module loader_assertions (
    input logic clk,
    input logic rst_n,
    input logic downloading,
    input logic ioctl_wr,
    input logic sdram_ack,
    input logic prog_we,
    input logic prom_we
);
    int fail_count = 0;

    // SDRAM write held until the controller takes it
    hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we && !sdram_ack |=> prog_we)
        else begin
            fail_count++;
            $error("prog_we dropped before sdram_ack");
        end

    // PROM strobe is a single pulse
    prom_single: assert property (@(posedge clk) disable iff (!rst_n)
        prom_we |=> !prom_we)
        else begin
            fail_count++;
            $error("prom_we held longer than one cycle");
        end

    // Downloader must not strobe into a pending write
    no_strobe_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (prog_we || prom_we) |-> !(downloading && ioctl_wr))
        else begin
            fail_count++;
            $error("ioctl_wr strobe while a write was pending");
        end

endmodule

bind dwnld_fsm loader_assertions u_loader_assertions (
    .clk(clk), .rst_n(rst_n), .downloading(downloading), .ioctl_wr(ioctl_wr),
    .sdram_ack(sdram_ack), .prog_we(prog_we), .prom_we(prom_we)
);

// File: tb/loader_checker.sv
// ROM loader output checker
`timescale 1ns/100ps

`include "loader_params.svh"

module loader_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 vsync60,
    input  logic                 downloading,
    input  logic [`DL_AW-1:0]    ioctl_addr,
    input  logic [7:0]           ioctl_dout,
    input  logic                 ioctl_wr,
    input  logic                 sdram_ack,
    input  logic                 dwnld_busy,
    input  logic [`PROG_AW-1:0]  prog_addr,
    input  logic [7:0]           prog_data,
    input  logic [1:0]           prog_mask,
    input  logic                 prog_we,
    input  logic                 prom_we,
    input  logic                 pxl2_cen,
    input  logic                 pxl_cen,
    output int                   checks,
    output int                   errors
);
    logic                exp_we;
    logic                exp_prom;
    logic [`PROG_AW-1:0] exp_addr;
    logic [7:0]          exp_data;
    logic [1:0]          exp_mask;
    logic                rst_seen;
    int                  clocks;
    int                  pxl2_count;
    int                  pxl_count;
    int                  want;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Expected write for one download byte from the memory map rules
    task automatic predict_write(input logic [`DL_AW-1:0] a, input logic [7:0] d);
        logic [`DL_AW-1:0] r;
        r        = a;
        exp_data = d;
        exp_we   = 1'b1;
        exp_prom = 1'b0;
        if (a >= `PROM_START) begin
            r        = a - `PROM_START;
            exp_we   = 1'b0;
            exp_prom = 1'b1;
        end else if (a >= `DL_AW'(`OBJ_START)) begin
            r[15]  = a[0];
            r[14]  = a[15];
            r[0]   = a[14];
            r[2:1] = a[5:4] + 2'd1;
            r[6:3] = {a[6], a[3], a[2], a[1]};
        end else if (a >= `DL_AW'(`SCR_START)) begin
            exp_data = {d[3:0], d[7:4]};
        end
        exp_mask = r[0] ? 2'b01 : 2'b10;
        exp_addr = exp_prom ? r[`PROG_AW-1:0] : r[`PROG_AW:1];
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            exp_we     = 1'b0;
            exp_prom   = 1'b0;
            rst_seen   = 1'b0;
            clocks     = 0;
            pxl2_count = 0;
            pxl_count  = 0;
        end else begin
            check_value("dwnld_busy", 32'(dwnld_busy), 32'(downloading));
            check_value("prog_we", 32'(prog_we), 32'(exp_we));
            check_value("prom_we", 32'(prom_we), 32'(exp_prom));
            if (exp_we || exp_prom) begin
                check_value("prog_addr", 32'(prog_addr), 32'(exp_addr));
                check_value("prog_data", 32'(prog_data), 32'(exp_data));
            end
            if (exp_we) begin
                check_value("prog_mask", 32'(prog_mask), 32'(exp_mask));
            end
            // Step the write model by one clock
            if (exp_prom) begin
                exp_prom = 1'b0;
            end else if (exp_we) begin
                exp_we = !sdram_ack;
            end else if (downloading && ioctl_wr) begin
                predict_write(ioctl_addr, ioctl_dout);
            end
            // floor(k*n/m) enables after k clocks
            if (rst_seen) begin
                clocks = clocks + 1;
                if (pxl2_cen) pxl2_count = pxl2_count + 1;
                if (pxl_cen) pxl_count = pxl_count + 1;
            end else begin
                // Enables still at their reset value
                check_value("pxl2_cen", 32'(pxl2_cen), 32'd0);
                check_value("pxl_cen", 32'(pxl_cen), 32'd0);
            end
            rst_seen = 1'b1;
            want = vsync60 ? clocks / 4 : (clocks * 32) / 125;
            check_value("pxl2_cen count", pxl2_count, want);
            check_value("pxl_cen count", pxl_count, want / 2);
        end
    end

endmodule

// File: tb/tb_rom_loader.sv
// ROM loader testbench
`timescale 1ns/100ps

`include "loader_params.svh"

module tb_rom_loader;
    localparam int rows       = 12;
    localparam int wait_limit = 40;

    logic                clk;
    logic                rst_n;
    logic                vsync60;
    logic                downloading;
    logic [`DL_AW-1:0]   ioctl_addr;
    logic [7:0]          ioctl_dout;
    logic                ioctl_wr;
    logic                sdram_ack;
    logic                dwnld_busy;
    logic [`PROG_AW-1:0] prog_addr;
    logic [7:0]          prog_data;
    logic [1:0]          prog_mask;
    logic                prog_we;
    logic                prom_we;
    logic                pxl2_cen;
    logic                pxl_cen;
    int                  checks;
    int                  errors;
    int                  assert_fails;
    int                  i;
    integer              seed;
    logic                timed_out;

    // Code, scroll, object with pair 0..3, PROM, then two with downloading low
    logic [`DL_AW-1:0] tbl_addr [rows] = '{
        25'h000124, 25'h00ff3b, 25'h010000, 25'h017fff, 25'h018000, 25'h018010,
        25'h01c06b, 25'h01fff1, 25'h020000, 25'h0201a5, 25'h000200, 25'h01a020};
    logic [7:0] tbl_data [rows] = '{
        8'h5a, 8'hc3, 8'h12, 8'ha7, 8'h96, 8'h0f, 8'he1, 8'h7d, 8'h3c, 8'h81, 8'hff, 8'h44};
    logic tbl_dl [rows] = '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 0};
    int   tbl_delay [rows];

    rom_loader_top u_rom_loader_top (.*);
    loader_checker u_loader_checker (.*);

    assign assert_fails = u_rom_loader_top.u_dwnld_fsm.u_loader_assertions.fail_count;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic hold_reset();
        rst_n = 1'b0;
        repeat (2) next_cycle();
        rst_n = 1'b1;
    endtask

    // One strobe, then the SDRAM side answers after the row's delay
    task automatic apply_row(input int r);
        int n;
        downloading = tbl_dl[r];
        ioctl_addr  = tbl_addr[r];
        ioctl_dout  = tbl_data[r];
        ioctl_wr    = 1'b1;
        next_cycle();
        ioctl_wr    = 1'b0;
        if (tbl_dl[r]) begin
            n = 0;
            while (!prog_we && !prom_we && n < wait_limit) begin
                next_cycle();
                n++;
            end
            if (!prog_we && !prom_we) begin
                $display("Timeout: no write started for table row %0d", r);
                timed_out = 1'b1;
            end else if (prog_we) begin
                repeat (tbl_delay[r]) next_cycle();
                sdram_ack = 1'b1;
                next_cycle();
                sdram_ack = 1'b0;
                n = 0;
                while (prog_we && n < wait_limit) begin
                    next_cycle();
                    n++;
                end
                if (prog_we) begin
                    $display("Timeout: prog_we never released for table row %0d", r);
                    timed_out = 1'b1;
                end
            end
        end
        next_cycle();
    endtask

    initial begin
        seed = 32'hed2c6e39;
        for (i = 0; i < rows; i++) tbl_delay[i] = $unsigned($random(seed)) % 6;
        rst_n       = 1'b0;
        vsync60     = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = 8'h00;
        ioctl_wr    = 1'b0;
        sdram_ack   = 1'b0;
        timed_out   = 1'b0;
        hold_reset();
        for (i = 0; i < rows && !timed_out; i++) apply_row(i);
        downloading = 1'b0;
        if (!timed_out) begin
            // Pixel enables at both ratios with a fresh reset for each
            hold_reset();
            // One extra clock so the checker samples the 400th
            repeat (401) next_cycle();
            vsync60 = 1'b0;
            hold_reset();
            // One extra clock so the checker samples the 1000th
            repeat (1001) next_cycle();
        end
        $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
                 checks, errors, assert_fails, timed_out);
        if (errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
